// File: build.f
+incdir+verif
verilog/mapper_cfg_pkg.sv
verilog/nes_bus_pkg.sv
verilog/cnrom_cpu_map.sv
verilog/cnrom_ppu_map.sv
verilog/cnrom_data_merge.sv
verilog/cnrom_mapper.sv
verif/tb_cnrom_mapper.sv

// File: verif/tb_cnrom_vectors.svh
`ifndef tb_cnrom_vectors_svh
`define tb_cnrom_vectors_svh

// columns: op, addr, data, rnd, act, exp_oe, exp_do, exp_bit
// cfg rows carry map_idx in addr and {mir_v, chr_ram, map_sub} in data[5:0]
localparam int n_vec = 34;

localparam vec_t vec_tab [n_vec] = '{
	// vertical mirroring, plain board
	'{op_cfg,    16'h0003, 8'h20, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0000, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},  // bank 0 after reset
	'{op_cpu_wr, 16'h8000, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0123, 8'h00, 1'b0, 1'b0, 1'b1, 8'h23, 1'b0},
	'{op_cpu_wr, 16'hc0f0, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h1fff, 8'h00, 1'b0, 1'b0, 1'b1, 8'hff, 1'b1},
	// bus conflict board
	'{op_cfg,    16'h0003, 8'h22, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1},
	'{op_cpu_wr, 16'h9aa0, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0},  // rom byte 05
	'{op_ppu_rd, 16'h0a00, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},
	'{op_cpu_wr, 16'hff5c, 8'h00, 1'b1, 1'b0, 1'b0, 8'h00, 1'b0},  // rom byte f9
	'{op_ppu_rd, 16'h0400, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b1},
	// horizontal mirroring with chr ram
	'{op_cfg,    16'h0003, 8'h10, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0400, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0800, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b1},
	'{op_ppu_rd, 16'h2800, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1},  // nametable
	'{op_ppu_wr, 16'h0010, 8'h77, 1'b0, 1'b0, 1'b0, 8'h00, 1'b1},
	'{op_cfg,    16'h0003, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_ppu_wr, 16'h0010, 8'h77, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},  // chr rom ignores it
	// cpu windows
	'{op_cpu_rd, 16'h5fff, 8'h00, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_cpu_rd, 16'h6000, 8'h00, 1'b0, 1'b0, 1'b1, 8'h3c, 1'b0},
	'{op_cpu_rd, 16'h7fff, 8'h00, 1'b0, 1'b0, 1'b1, 8'h3c, 1'b0},
	'{op_cpu_rd, 16'h8012, 8'h00, 1'b0, 1'b0, 1'b1, 8'hb7, 1'b0},
	'{op_cpu_rd, 16'hffff, 8'h00, 1'b0, 1'b0, 1'b1, 8'h5a, 1'b0},
	'{op_cpu_wr, 16'h6010, 8'h99, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	// save state
	'{op_sst_wr, 16'h0000, 8'h0b, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0100, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},
	'{op_cpu_wr, 16'h8000, 8'h05, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0},  // engine active
	'{op_sst_rd, 16'h0000, 8'h00, 1'b0, 1'b1, 1'b0, 8'h0b, 1'b0},
	'{op_sst_rd, 16'h007f, 8'h00, 1'b0, 1'b1, 1'b0, 8'h03, 1'b0},
	'{op_sst_rd, 16'h0042, 8'h00, 1'b0, 1'b1, 1'b0, 8'hff, 1'b0},
	'{op_sst_wr, 16'h0005, 8'h07, 1'b0, 1'b1, 1'b0, 8'h00, 1'b0},
	'{op_ppu_rd, 16'h0000, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00, 1'b0},
	'{op_cpu_wr, 16'h8000, 8'h06, 1'b0, 1'b0, 1'b0, 8'h00, 1'b0},
	'{op_sst_rd, 16'h0000, 8'h00, 1'b0, 1'b1, 1'b0, 8'h06, 1'b0}
};

`endif

// File: verif/tb_cnrom_mapper.sv
`default_nettype none

module tb_cnrom_mapper
	import mapper_cfg_pkg::*, nes_bus_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	typedef enum logic [2:0]
	{
		op_cfg, op_cpu_rd, op_cpu_wr, op_ppu_rd, op_ppu_wr, op_sst_wr, op_sst_rd
	} op_t;

	// one table row whose expected fields depend on op
	typedef struct packed
	{
		op_t         op;
		logic [15:0] addr;
		logic [7:0]  data;
		logic        rnd;      // data replaced by a random byte
		logic        act;      // sst.act held during the row
		logic        exp_oe;   // map_cpu_oe or map_ppu_oe
		logic [7:0]  exp_do;   // read data or sst_di
		logic        exp_bit;  // bus_cf, ciram_a10 or chr.we
	} vec_t;

	`include "tb_cnrom_vectors.svh"

	localparam int reset_cycles = 16;

	logic       m2;
	logic       rst_n;
	cpu_bus_t   cpu;
	ppu_bus_t   ppu;
	sys_cfg_t   cfg;
	sst_bus_t   sst;
	map_in_t    mai;
	map_out_t   mao;
	logic [3:0] bank_ref;  // expected bank latch

	// memory models in the order prg_do, chr_do, srm_do
	assign mai = {cpu, ppu, cfg, sst, cpu.addr[7:0] ^ 8'ha5, ppu.addr[7:0], 8'h3c};

	cnrom_mapper dut_i
	(
		.m2    (m2),
		.rst_n (rst_n),
		.mai   (mai),
		.mao   (mao)
	);

	initial
	begin
		m2 = 1'b1;
		forever #50 m2 = ~m2;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
			$display("TB FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// bank held after the next falling edge
	function automatic logic [3:0] next_bank(input vec_t v, input logic [7:0] d);
		logic [7:0] mask;
		mask = (cfg.map_sub == sub_bus_conflict) ? (v.addr[7:0] ^ 8'ha5) : 8'hff;
		if (v.op == op_cpu_wr && !v.act && v.addr >= 16'h8000)
			return d[3:0] & mask[3:0];  // rom byte fights the cpu on conflict boards
		else if (v.op == op_sst_wr && v.addr[7:0] == 8'h00)
			return d[3:0];
		return bank_ref;
	endfunction

	task automatic check_row(input vec_t v, input logic [7:0] wdata);
		logic chr_win;
		chr_win = v.addr < 16'h2000;
		check_value("irq", mao.irq, 1'b0);
		check_value("prg.we", mao.prg.we, 1'b0);
		case (v.op)
			op_cfg:
				check_value("bus_cf", mao.bus_cf, v.exp_bit);
			op_cpu_rd, op_cpu_wr:
			begin
				check_value("map_cpu_oe", mao.map_cpu_oe, v.exp_oe);
				check_value("srm.ce", mao.srm.ce, v.addr >= 16'h6000 && v.addr <= 16'h7fff);
				check_value("prg.ce", mao.prg.ce, v.addr >= 16'h8000);
				check_value("srm.we", mao.srm.we, v.op == op_cpu_wr);
				check_value("srm.addr", mao.srm.addr, v.addr[12:0]);
				check_value("prg.addr", mao.prg.addr, v.addr[14:0]);
				if (v.op == op_cpu_wr)
				begin
					check_value("srm.dati", mao.srm.dati, wdata);
					check_value("prg.dati", mao.prg.dati, wdata);
				end
				if (v.exp_oe)
					check_value("map_cpu_do", mao.map_cpu_do, v.exp_do);
			end
			op_ppu_rd, op_ppu_wr:
			begin
				check_value("map_ppu_oe", mao.map_ppu_oe, v.exp_oe);
				check_value("chr.ce", mao.chr.ce, chr_win);
				check_value("ciram_ce", mao.ciram_ce, chr_win);
				if (v.op == op_ppu_wr)
				begin
					check_value("chr.we", mao.chr.we, v.exp_bit);
					check_value("chr.dati", mao.chr.dati, wdata);
				end
				else
					check_value("ciram_a10", mao.ciram_a10, v.exp_bit);
				if (v.exp_oe)
				begin
					check_value("map_ppu_do", mao.map_ppu_do, v.exp_do);
					check_value("chr.addr", mao.chr.addr, {bank_ref, v.addr[12:0]});
				end
			end
			op_sst_rd:
				check_value("sst_di", mao.sst_di, v.exp_do);
			default:
				;
		endcase
	endtask

	initial
	begin
		vec_t        v;
		logic [7:0]  wdata;
		int unsigned rnd_word;
		rnd_word = $urandom(65314);
		rst_n    = 1'b0;
		cpu      = '{16'h0000, 8'h00, 1'b1};
		ppu      = '{14'h2000, 8'h00, 1'b1, 1'b1};
		cfg      = '{8'd3, sub_plain, 1'b0, 1'b0};
		sst      = '0;
		bank_ref = 4'h0;
		repeat (reset_cycles) @(negedge m2);
		rst_n <= 1'b1;
		foreach (vec_tab[i])
		begin
			v        = vec_tab[i];
			rnd_word = $urandom;
			wdata    = v.rnd ? rnd_word[7:0] : v.data;
			@(negedge m2);
			// buses not addressed by the row stay idle through their strobes
			cpu <= '{v.addr, wdata, v.op != op_cpu_wr};
			ppu <= '{v.addr[13:0], wdata, v.op != op_ppu_rd, v.op != op_ppu_wr};
			sst <= '{v.act || v.op == op_sst_wr || v.op == op_sst_rd,
				v.op == op_sst_wr, v.addr[7:0], wdata};
			if (v.op == op_cfg)
				cfg <= '{v.addr[7:0], submapper_t'(v.data[3:0]), v.data[5], v.data[4]};
			bank_ref = next_bank(v, wdata);
			@(posedge m2);
			check_row(v, wdata);
		end
		@(negedge m2);
		$display("TB PASSED");
		$finish;
	end

	initial
	begin
		#(reset_cycles * 100 + n_vec * 200);
		$display("timeout: the vector table did not finish in time");
		$display("TB FAILED");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: verilog/cnrom_cpu_map.sv
`default_nettype none

module cnrom_cpu_map
	import mapper_cfg_pkg::*, nes_bus_pkg::*;
(
	input  logic                  m2,
	input  logic                  rst_n,
	input  cpu_bus_t              cpu,
	input  sys_cfg_t              cfg,
	input  sst_bus_t              sst,
	input  logic [7:0]            prg_do,
	output mem_ctrl_t             prg,
	output mem_ctrl_t             srm,
	output logic [chr_bank_w-1:0] chr_bank,
	output logic                  bus_cf,
	output logic [7:0]            sst_di
);

	logic [7:0] bank_wr;  // value a cpu write would latch
	logic       cpu_bank_we;

	// save ram sits in the 6000-7fff window
	always_comb
	begin
		srm      = '0;
		srm.ce   = cpu.addr[15:13] == srm_base[15:13];
		srm.oe   = cpu.rw;
		srm.we   = !cpu.rw;
		srm.addr[srm_addr_w-1:0] = cpu.addr[srm_addr_w-1:0];
		srm.dati = '0;  // write data joined at the top level
	end

	// prg rom fills the upper half and is never written
	always_comb
	begin
		prg      = '0;
		prg.ce   = cpu.addr[15];
		prg.oe   = cpu.rw;
		prg.we   = 1'b0;
		prg.addr[prg_addr_w-1:0] = cpu.addr[prg_addr_w-1:0];
		prg.dati = '0;
	end

	assign bus_cf = cfg.map_sub == sub_bus_conflict;

	// on conflict boards the rom drives the bus at the same time
	// so a bit stays high only where both sides drive it high
	assign bank_wr = bus_cf ? (cpu.data & prg_do) : cpu.data;

	assign cpu_bank_we = cpu.addr[15] && !cpu.rw;  // any write to 8000-ffff

	// latch at the end of the bus cycle
	always_ff @(negedge m2 or negedge rst_n)
	begin
		if (!rst_n)
			chr_bank <= '0;
		else if (sst.act)
		begin
			// cpu writes are ignored while the save-state engine is active
			if (sst.we_reg && sst.addr == sst_reg_bank)
				chr_bank <= sst.dato[chr_bank_w-1:0];
		end
		else if (cpu_bank_we)
			chr_bank <= bank_wr[chr_bank_w-1:0];
	end

	// save-state readback
	always_comb
	begin
		if (sst.addr == sst_reg_bank)
			sst_di = 8'(chr_bank);  // zero-extended bank
		else if (sst.addr == sst_reg_idx)
			sst_di = cfg.map_idx;
		else
			sst_di = sst_idle_value;
	end

endmodule

`default_nettype wire

// File: verilog/cnrom_data_merge.sv
`default_nettype none

module cnrom_data_merge
	import nes_bus_pkg::*;
(
	input  mem_ctrl_t  prg,
	input  mem_ctrl_t  srm,
	input  mem_ctrl_t  chr,
	input  logic [7:0] prg_do,
	input  logic [7:0] srm_do,
	input  logic [7:0] chr_do,
	output logic       cpu_oe,
	output logic [7:0] cpu_do,
	output logic       ppu_oe,
	output logic [7:0] ppu_do
);

	logic srm_rd;
	logic prg_rd;

	assign srm_rd = srm.ce && srm.oe;
	assign prg_rd = prg.ce && prg.oe;

	// cpu side drives the bus only on a selected read
	assign cpu_oe = srm_rd || prg_rd;

	// save ram wins when both windows would answer
	assign cpu_do = srm.ce ? srm_do : prg_do;

	assign ppu_oe = chr.ce && chr.oe;
	assign ppu_do = chr_do;  // chr is the only ppu source here

endmodule

`default_nettype wire

// File: verilog/cnrom_mapper.sv
`default_nettype none

module cnrom_mapper
	import mapper_cfg_pkg::*, nes_bus_pkg::*;
(
	input  logic     m2,
	input  logic     rst_n,
	input  map_in_t  mai,
	output map_out_t mao
);

	cpu_bus_t cpu;
	ppu_bus_t ppu;
	sys_cfg_t cfg;
	sst_bus_t sst;

	mem_ctrl_t             prg;
	mem_ctrl_t             srm;
	mem_ctrl_t             chr;
	logic [chr_bank_w-1:0] chr_bank;
	logic                  bus_cf;
	logic [7:0]            sst_di;
	logic                  ciram_a10;
	logic                  ciram_ce;
	logic                  cpu_oe;
	logic [7:0]            cpu_do;
	logic                  ppu_oe;
	logic [7:0]            ppu_do;

	assign cpu = mai.cpu;
	assign ppu = mai.ppu;
	assign cfg = mai.cfg;
	assign sst = mai.sst;

	cnrom_cpu_map cpu_map_i
	(
		.m2       (m2),
		.rst_n    (rst_n),
		.cpu      (cpu),
		.cfg      (cfg),
		.sst      (sst),
		.prg_do   (mai.prg_do),  // needed for bus conflict masking
		.prg      (prg),
		.srm      (srm),
		.chr_bank (chr_bank),
		.bus_cf   (bus_cf),
		.sst_di   (sst_di)
	);

	cnrom_ppu_map ppu_map_i
	(
		.ppu       (ppu),
		.cfg       (cfg),
		.chr_bank  (chr_bank),
		.chr       (chr),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce)
	);

	cnrom_data_merge data_merge_i
	(
		.prg    (prg),
		.srm    (srm),
		.chr    (chr),
		.prg_do (mai.prg_do),
		.srm_do (mai.srm_do),
		.chr_do (mai.chr_do),
		.cpu_oe (cpu_oe),
		.cpu_do (cpu_do),
		.ppu_oe (ppu_oe),
		.ppu_do (ppu_do)
	);

	always_comb
	begin
		mao.prg        = prg;
		mao.prg.dati   = cpu.data;
		mao.srm        = srm;
		mao.srm.dati   = cpu.data;
		mao.chr        = chr;
		mao.chr.dati   = ppu.data;  // chr ram takes ppu write data
		mao.map_cpu_oe = cpu_oe;
		mao.map_cpu_do = cpu_do;
		mao.map_ppu_oe = ppu_oe;
		mao.map_ppu_do = ppu_do;
		mao.ciram_a10  = ciram_a10;
		mao.ciram_ce   = ciram_ce;
		mao.bus_cf     = bus_cf;
		mao.irq        = 1'b0;  // no interrupt source on this board
		mao.sst_di     = sst_di;
	end

endmodule

`default_nettype wire

// File: verilog/cnrom_ppu_map.sv
`default_nettype none

module cnrom_ppu_map
	import mapper_cfg_pkg::*, nes_bus_pkg::*;
(
	input  ppu_bus_t              ppu,
	input  sys_cfg_t              cfg,
	input  logic [chr_bank_w-1:0] chr_bank,
	output mem_ctrl_t             chr,
	output logic                  ciram_a10,
	output logic                  ciram_ce
);

	logic chr_sel;  // pattern table region 0000-1fff

	assign chr_sel = !ppu.addr[13];

	always_comb
	begin
		chr      = '0;
		chr.ce   = chr_sel;
		chr.oe   = !ppu.oe;
		chr.we   = cfg.chr_ram && !ppu.we && chr_sel;  // rom boards never write
		chr.addr = {chr_bank, ppu.addr[chr_addr_w-1:0]};
		chr.dati = '0;  // filled in at the top level
	end

	// a10 for vertical, a11 for horizontal mirroring
	assign ciram_a10 = cfg.mir_v ? ppu.addr[10] : ppu.addr[11];
	assign ciram_ce  = !ppu.addr[13];

endmodule

`default_nettype wire

// File: verilog/mapper_cfg_pkg.sv
`default_nettype none

package mapper_cfg_pkg;

	// board variant as given by the cartridge header
	typedef enum logic [3:0]
	{
		sub_plain        = 4'd0,
		sub_alt          = 4'd1,
		sub_bus_conflict = 4'd2  // bank write is ANDed with the rom byte
	} submapper_t;

	// cartridge configuration, static while the game runs
	typedef struct packed
	{
		logic [7:0] map_idx;   // mapper number, read back by the save-state engine
		submapper_t map_sub;
		logic       mir_v;     // 1 = vertical mirroring
		logic       chr_ram;   // 1 = chr is writable ram
	} sys_cfg_t;

	// save-state engine access to mapper registers
	typedef struct packed
	{
		logic       act;       // engine owns the mapper registers
		logic       we_reg;    // register write strobe
		logic [7:0] addr;
		logic [7:0] dato;      // value to restore
	} sst_bus_t;

	// register addresses seen by the save-state engine
	localparam logic [7:0] sst_reg_bank   = 8'd0;
	localparam logic [7:0] sst_reg_idx    = 8'd127;

	// returned for any unused register address
	localparam logic [7:0] sst_idle_value = 8'hff;

endpackage

`default_nettype wire

// File: verilog/nes_bus_pkg.sv
`default_nettype none

package nes_bus_pkg;

	import mapper_cfg_pkg::*;

	// cpu side of the cartridge edge
	typedef struct packed
	{
		logic [15:0] addr;
		logic [7:0]  data;  // value written by the cpu
		logic        rw;    // 1 = read
	} cpu_bus_t;

	// ppu side, strobes active low as on the connector
	typedef struct packed
	{
		logic [13:0] addr;
		logic [7:0]  data;
		logic        oe;
		logic        we;
	} ppu_bus_t;

	// controls for one external memory
	typedef struct packed
	{
		logic        ce;
		logic        oe;
		logic        we;
		logic [16:0] addr;  // unused upper bits stay zero
		logic [7:0]  dati;
	} mem_ctrl_t;

	typedef struct packed
	{
		cpu_bus_t   cpu;
		ppu_bus_t   ppu;
		sys_cfg_t   cfg;
		sst_bus_t   sst;
		logic [7:0] prg_do;
		logic [7:0] chr_do;
		logic [7:0] srm_do;
	} map_in_t;

	typedef struct packed
	{
		mem_ctrl_t  prg;
		mem_ctrl_t  chr;
		mem_ctrl_t  srm;
		logic       map_cpu_oe;
		logic [7:0] map_cpu_do;
		logic       map_ppu_oe;
		logic [7:0] map_ppu_do;
		logic       ciram_a10;
		logic       ciram_ce;
		logic       bus_cf;
		logic       irq;
		logic [7:0] sst_di;
	} map_out_t;

	// fixed windows of the board
	localparam logic [15:0] srm_base = 16'h6000;
	localparam int srm_addr_w = 13;  // 8 KB save ram
	localparam int prg_addr_w = 15;  // 32 KB prg rom, no banking
	localparam int chr_addr_w = 13;  // 8 KB chr window
	localparam int chr_bank_w = 4;

endpackage

`default_nettype wire
